// File: verilog/gf_pkg.sv
package gf_pkg;

	// ####################################################################
	// field limits
	// ####################################################################

	// widest field the unit is built for
	localparam int GF_M_MAX = 8;

	// ####################################################################
	// encodings
	// ####################################################################

	// operation code on the input channel
	typedef enum logic [1:0] {
		OP_ADD  = 2'd0,	// bitwise xor
		OP_MUL  = 2'd1,	// a * b
		OP_CUBE = 2'd2,	// a * a * a
		OP_DIV  = 2'd3	// a / b, serial
	} gf_op_t;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,	// ready for an operation
		ST_DIV  = 2'd1,	// divider running
		ST_HOLD = 2'd2	// result waiting on out_ready
	} gf_state_t;

	// ####################################################################
	// primitive polynomials
	// ####################################################################

	// low m bits of the primitive polynomial, x^m term implied
	function automatic logic [GF_M_MAX-1:0] gf_poly(input int m);
		case (m)
			4: return 8'h03;	// x^4 + x + 1
			5: return 8'h05;	// x^5 + x^2 + 1
			6: return 8'h03;	// x^6 + x + 1
			7: return 8'h03;	// x^7 + x + 1
			8: return 8'h1d;	// x^8 + x^4 + x^3 + x^2 + 1
			default: return '0;	// unsupported width
		endcase
	endfunction

endpackage

// File: verilog/gf_mult.sv
`timescale 1ns/1ps

// bit-parallel standard basis multiplier, product = a * b
module gf_mult import gf_pkg::*; #(
	parameter int M = 8
) (
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic [M-1:0] product
);

	localparam logic [GF_M_MAX-1:0] POLY_FULL = gf_poly(M);
	localparam logic [M-1:0] POLY = POLY_FULL[M-1:0];

	// chain[i] holds a * alpha^i
	logic [M-1:0][M-1:0] chain;

	genvar i, j;

	// ####################################################################
	// multiply-by-alpha chain
	// ####################################################################

	assign chain[0] = a;

	for (i = 1; i < M; i++) begin : g_chain
		// shift up, fold the carried-out bit back through the polynomial
		assign chain[i] = {chain[i-1][M-2:0], 1'b0} ^ (POLY & {M{chain[i-1][M-1]}});
	end

	// ####################################################################
	// product bits
	// ####################################################################

	for (i = 0; i < M; i++) begin : g_bit
		logic [M-1:0] z;	// bit i of every chain entry

		for (j = 0; j < M; j++) begin : g_sel
			assign z[j] = chain[j][i];
		end

		// sum of b_j * (a * alpha^j), bit i
		assign product[i] = ^(z & b);
	end

endmodule

// File: verilog/gf_cube.sv
`timescale 1ns/1ps

// cube network, cheaper than a squarer feeding a full multiplier
module gf_cube import gf_pkg::*; #(
	parameter int M = 8
) (
	input  logic [M-1:0] a,
	output logic [M-1:0] cube
);

	localparam logic [GF_M_MAX-1:0] POLY_FULL = gf_poly(M);
	localparam logic [M-1:0] POLY = POLY_FULL[M-1:0];

	// alpha^e in the standard basis, evaluated at elaboration
	function automatic logic [M-1:0] alpha_pow(input int e);
		logic [M-1:0] r;
		r = {{(M-1){1'b0}}, 1'b1};
		for (int k = 0; k < e; k++) begin
			r = {r[M-2:0], 1'b0} ^ (POLY & {M{r[M-1]}});
		end
		return r;
	endfunction

	logic [M-1:0] first_term [M];
	logic [M-1:0] cross_term [M][M];
	logic [M-1:0] cube_acc;

	genvar i, j;

	// ####################################################################
	// term generation
	// ####################################################################

	for (i = 0; i < M; i++) begin : g_first
		localparam logic [M-1:0] P3 = alpha_pow(3 * i);
		assign first_term[i] = P3 & {M{a[i]}};	// a_i * alpha^(3i)
	end

	for (i = 0; i < M; i++) begin : g_row
		for (j = 0; j < M; j++) begin : g_col
			if (i < j) begin : g_pair
				// alpha^(2i+j) + alpha^(2j+i)
				localparam logic [M-1:0] PC = alpha_pow(2*i + j) ^ alpha_pow(2*j + i);
				assign cross_term[i][j] = PC & {M{a[i] & a[j]}};
			end else begin : g_none
				assign cross_term[i][j] = '0;	// only i < j pairs contribute
			end
		end
	end

	// sum all terms
	always_comb begin
		cube_acc = '0;
		for (int p = 0; p < M; p++) begin
			cube_acc ^= first_term[p];
			for (int q = 0; q < M; q++) begin
				cube_acc ^= cross_term[p][q];
			end
		end
	end

	assign cube = cube_acc;

endmodule

// File: verilog/gf_divider.sv
`timescale 1ns/1ps

// serial fermat divider
// quotient = numer * denom^(2^M - 2), built up over M-1 steps as
// numer * denom^2 * denom^4 * ... * denom^(2^(M-1))
module gf_divider #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic [M-1:0] numer,
	input  logic [M-1:0] denom,
	output logic [M-1:0] quotient,
	output logic         done
);

	localparam int CW = $clog2(M);

	logic [M-1:0]  sq_reg;		// denom^(2^(k+1)) after k steps
	logic [M-1:0]  acc_reg;		// running product
	logic [M-1:0]  sq_in;
	logic [M-1:0]  sq_next;
	logic [M-1:0]  acc_next;
	logic [CW-1:0] cnt;		// steps left
	logic          busy;

	// ####################################################################
	// datapath
	// ####################################################################

	// on start the squarer sees denom, so sq_reg loads denom^2
	assign sq_in = start ? denom : sq_reg;

	gf_mult #(.M(M)) u_square (
		.a       (sq_in),
		.b       (sq_in),
		.product (sq_next)
	);

	gf_mult #(.M(M)) u_accum (
		.a       (acc_reg),
		.b       (sq_reg),
		.product (acc_next)
	);

	always_ff @(posedge clk) begin
		if (start) begin
			sq_reg  <= sq_next;
			acc_reg <= numer;
		end else if (busy) begin
			sq_reg  <= sq_next;	// square again
			acc_reg <= acc_next;	// fold in the next power
		end
	end

	assign quotient = acc_reg;

	// ####################################################################
	// step control
	// ####################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= CW'(M - 1);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == CW'(1)) begin
					busy <= 1'b0;	// last step
					done <= 1'b1;	// quotient valid next cycle
				end
			end
		end
	end

endmodule

// File: verilog/gf_alu_ctrl.sv
`timescale 1ns/1ps

// accept / dispatch / hold controller with the result register
module gf_alu_ctrl import gf_pkg::*; #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,

	// input channel
	input  logic         in_valid,
	output logic         in_ready,
	input  gf_op_t       in_op,
	input  logic [M-1:0] in_a,
	input  logic [M-1:0] in_b,

	// output channel
	output logic         out_valid,
	input  logic         out_ready,
	output logic [M-1:0] out_result,

	// combinational units
	output logic [M-1:0] mul_a,
	output logic [M-1:0] mul_b,
	input  logic [M-1:0] product,
	input  logic [M-1:0] cube,

	// divider
	output logic         div_start,
	output logic [M-1:0] div_numer,
	output logic [M-1:0] div_denom,
	input  logic [M-1:0] quotient,
	input  logic         div_done
);

	gf_state_t    state;
	logic [M-1:0] result;
	logic         accept;
	logic         div_finish;

	assign in_ready   = (state == ST_IDLE);
	assign out_valid  = (state == ST_HOLD);
	assign out_result = result;

	assign accept     = in_valid && in_ready;
	assign div_finish = (state == ST_DIV) && div_done;

	// operands go straight to the multiplier and the cube network
	assign mul_a = in_a;
	assign mul_b = in_b;

	// ####################################################################
	// state machine
	// ####################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			div_start <= 1'b0;
		end else begin
			div_start <= 1'b0;	// single cycle pulse
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (in_op == OP_DIV) begin
							div_start <= 1'b1;
							state     <= ST_DIV;
						end else begin
							state <= ST_HOLD;
						end
					end
				end
				ST_DIV: begin
					if (div_done)
						state <= ST_HOLD;
				end
				ST_HOLD: begin
					if (out_ready)
						state <= ST_IDLE;	// result taken
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ####################################################################
	// result and divider operands
	// ####################################################################

	always_ff @(posedge clk) begin
		if (accept) begin
			div_numer <= in_a;	// held for the divider load edge
			div_denom <= in_b;
			case (in_op)
				OP_ADD:  result <= in_a ^ in_b;
				OP_MUL:  result <= product;
				OP_CUBE: result <= cube;
				default: result <= result;	// division fills it later
			endcase
		end else if (div_finish) begin
			result <= quotient;
		end
	end

endmodule

// File: verilog/gf_alu.sv
`timescale 1ns/1ps

// GF(2^M) arithmetic unit, one operation in flight
module gf_alu import gf_pkg::*; #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,

	input  logic         in_valid,
	output logic         in_ready,
	input  gf_op_t       in_op,
	input  logic [M-1:0] in_a,
	input  logic [M-1:0] in_b,

	output logic         out_valid,
	input  logic         out_ready,
	output logic [M-1:0] out_result
);

	logic [M-1:0] mul_a;
	logic [M-1:0] mul_b;
	logic [M-1:0] product;
	logic [M-1:0] cube;
	logic         div_start;
	logic [M-1:0] div_numer;
	logic [M-1:0] div_denom;
	logic [M-1:0] quotient;
	logic         div_done;

	gf_alu_ctrl #(.M(M)) u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.product    (product),
		.cube       (cube),
		.div_start  (div_start),
		.div_numer  (div_numer),
		.div_denom  (div_denom),
		.quotient   (quotient),
		.div_done   (div_done)
	);

	gf_mult #(.M(M)) u_mult (
		.a       (mul_a),
		.b       (mul_b),
		.product (product)
	);

	// cube shares the first operand with the multiplier
	gf_cube #(.M(M)) u_cube (
		.a    (mul_a),
		.cube (cube)
	);

	gf_divider #(.M(M)) u_div (
		.clk      (clk),
		.reset    (reset),
		.start    (div_start),
		.numer    (div_numer),
		.denom    (div_denom),
		.quotient (quotient),
		.done     (div_done)
	);

endmodule

// File: test/gf_alu_chk.sv
`timescale 1ns/1ps

// handshake checks on the gf_alu ports
module gf_alu_chk import gf_pkg::*; #(
	parameter int M = 8
) (
	input logic         clk,
	input logic         reset,
	input logic         in_ready,
	input logic         out_valid,
	input logic         out_ready,
	input logic [M-1:0] out_result,
	input gf_state_t    state
);

	// ####################################################################
	// channel rules
	// ####################################################################

	a_ready_valid_excl: assert property (@(posedge clk) disable iff (reset)
		!(in_ready && out_valid))
		else $error("in_ready and out_valid high together");

	// result held while the receiver stalls
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
		else $error("out_valid dropped or out_result changed under back-pressure");

	a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// quotient lands in ST_HOLD M+1 cycles after the division is taken
	a_div_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(state == ST_DIV) |-> ##(M+1) (state == ST_HOLD))
		else $error("division result not ready M+1 cycles after acceptance");

endmodule

bind gf_alu gf_alu_chk #(.M(M)) u_chk (
	.clk        (clk),
	.reset      (reset),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_result (out_result),
	.state      (u_ctrl.state)
);

// File: test/gf_alu_tb.sv
`timescale 1ns/1ps

module gf_alu_tb import gf_pkg::*; ();

	localparam int M = 8;
	localparam int N_TABLE = 15;
	localparam int N_RANDOM = 40;
	// one slot per operation plus the back-pressure test, plus reset
	localparam int LIMIT_CYCLES = (N_TABLE + N_RANDOM + 1) * (M + 8) + 20;

	logic         clk;
	logic         reset;
	logic         in_valid;
	logic         in_ready;
	gf_op_t       in_op;
	logic [M-1:0] in_a;
	logic [M-1:0] in_b;
	logic         out_valid;
	logic         out_ready;
	logic [M-1:0] out_result;

	integer seed;
	int     n_checks;
	int     n_errors;

	string        t_name [N_TABLE];
	gf_op_t       t_op   [N_TABLE];
	logic [M-1:0] t_a    [N_TABLE];
	logic [M-1:0] t_b    [N_TABLE];
	logic [M-1:0] t_exp  [N_TABLE];

	gf_alu #(.M(M)) dut (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(LIMIT_CYCLES * 100);
		$display("timeout: no result after %0d cycles, the DUT seems stuck", LIMIT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// ####################################################################
	// reference model, shift and reduce
	// ####################################################################

	function automatic logic [M-1:0] model_mul(input logic [M-1:0] a, input logic [M-1:0] b);
		logic [GF_M_MAX-1:0] full;
		logic [M-1:0]        poly;
		logic [M-1:0]        acc;
		logic [M-1:0]        sh;
		full = gf_poly(M);
		poly = full[M-1:0];
		acc = '0;
		sh = a;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				acc ^= sh;
			sh = {sh[M-2:0], 1'b0} ^ (sh[M-1] ? poly : '0);	// times x, reduced
		end
		return acc;
	endfunction

	// brute force search for q with q * b == a
	function automatic logic [M-1:0] model_div(input logic [M-1:0] a, input logic [M-1:0] b);
		if (b == '0)
			return '0;
		for (int q = 0; q < (1 << M); q++) begin
			if (model_mul(q[M-1:0], b) == a)
				return q[M-1:0];
		end
		return '0;
	endfunction

	function automatic logic [M-1:0] model_result(input gf_op_t op, input logic [M-1:0] a,
			input logic [M-1:0] b);
		case (op)
			OP_ADD:  return a ^ b;
			OP_MUL:  return model_mul(a, b);
			OP_CUBE: return model_mul(model_mul(a, a), a);
			default: return model_div(a, b);
		endcase
	endfunction

	// ####################################################################
	// stimulus table and channel tasks
	// ####################################################################

	task automatic set_entry(input int idx, input string name, input gf_op_t op,
			input logic [M-1:0] a, input logic [M-1:0] b, input logic [M-1:0] exp);
		t_name[idx] = name;
		t_op[idx]   = op;
		t_a[idx]    = a;
		t_b[idx]    = b;
		t_exp[idx]  = exp;
	endtask

	task automatic load_table();
		set_entry(0,  "add_basic",    OP_ADD,  8'h5a, 8'h3c, 8'h66);
		set_entry(1,  "add_self",     OP_ADD,  8'ha7, 8'ha7, 8'h00);
		set_entry(2,  "add_zero",     OP_ADD,  8'h00, 8'hff, 8'hff);
		set_entry(3,  "mul_one",      OP_MUL,  8'h01, 8'hb7, 8'hb7);
		set_entry(4,  "mul_wrap",     OP_MUL,  8'h02, 8'h80, 8'h1d);	// alpha^8
		set_entry(5,  "mul_zero",     OP_MUL,  8'h00, 8'hc3, 8'h00);
		set_entry(6,  "mul_alpha_sq", OP_MUL,  8'h02, 8'h02, 8'h04);
		set_entry(7,  "cube_alpha",   OP_CUBE, 8'h02, 8'h00, 8'h08);
		set_entry(8,  "cube_top",     OP_CUBE, 8'h80, 8'h00, 8'h75);	// alpha^21
		set_entry(9,  "cube_one",     OP_CUBE, 8'h01, 8'h00, 8'h01);
		set_entry(10, "div_by_one",   OP_DIV,  8'h9c, 8'h01, 8'h9c);
		set_entry(11, "div_self",     OP_DIV,  8'h4e, 8'h4e, 8'h01);
		set_entry(12, "div_by_zero",  OP_DIV,  8'h37, 8'h00, 8'h00);
		set_entry(13, "div_wrap",     OP_DIV,  8'h1d, 8'h80, 8'h02);
		set_entry(14, "div_zero_num", OP_DIV,  8'h00, 8'h55, 8'h00);
	endtask

	task automatic send_op(input gf_op_t op, input logic [M-1:0] a, input logic [M-1:0] b);
		logic taken;
		taken = 1'b0;
		@(posedge clk);
		in_valid <= 1'b1;
		in_op    <= op;
		in_a     <= a;
		in_b     <= b;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;	// transfer on the coming edge
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic take_result(output logic [M-1:0] value);
		logic got_it;
		got_it = 1'b0;
		value = '0;
		while (!got_it) begin
			@(negedge clk);
			if (out_valid && out_ready) begin
				value = out_result;
				got_it = 1'b1;
			end
			@(posedge clk);
			out_ready <= ($random(seed) % 4) != 0;	// mostly ready
		end
	endtask

	task automatic check_result(input string name, input logic [M-1:0] exp,
			input logic [M-1:0] got);
		n_checks++;
		assert (got === exp) else begin
			$display("FAIL %s: expected %02h, actual %02h", name, exp, got);
			n_errors++;
		end
	endtask

	task automatic run_op(input string name, input gf_op_t op, input logic [M-1:0] a,
			input logic [M-1:0] b, input logic [M-1:0] exp);
		logic [M-1:0] got;
		send_op(op, a, b);
		take_result(got);
		check_result(name, exp, got);
	endtask

	// stall the output and make sure nothing moves
	task automatic backpressure_test();
		logic [M-1:0] held;
		logic [M-1:0] got;
		@(posedge clk);
		out_ready <= 1'b0;
		send_op(OP_MUL, 8'h53, 8'hca);
		do @(negedge clk); while (!out_valid);
		held = out_result;
		repeat (6) begin
			@(negedge clk);
			n_checks++;
			assert (out_valid && out_result === held && !in_ready) else begin
				$display("back-pressure: result moved or input was ready while stalled");
				n_errors++;
			end
		end
		@(posedge clk);
		out_ready <= 1'b1;
		take_result(got);
		check_result("backpressure", model_mul(8'h53, 8'hca), got);
	endtask

	// ####################################################################
	// main sequence
	// ####################################################################

	initial begin
		logic [31:0]  r;
		gf_op_t       op;
		logic [M-1:0] a;
		logic [M-1:0] b;
		seed      = 32'h49be;
		n_checks  = 0;
		n_errors  = 0;
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_op     = OP_ADD;
		in_a      = '0;
		in_b      = '0;
		out_ready = 1'b0;
		load_table();

		assert (M >= 4 && M <= GF_M_MAX) else begin
			$display("field width %0d is outside the supported range", M);
			n_errors++;
		end

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		n_checks++;
		assert (in_ready === 1'b1 && out_valid === 1'b0) else begin
			$display("after reset the input is not ready or the output is already valid");
			n_errors++;
		end

		for (int i = 0; i < N_TABLE; i++)
			run_op(t_name[i], t_op[i], t_a[i], t_b[i], t_exp[i]);

		for (int i = 0; i < N_RANDOM; i++) begin
			r  = $random(seed);
			op = gf_op_t'(r[1:0]);
			a  = r[8 +: M];
			b  = r[16 +: M];
			run_op($sformatf("random_%0d", i), op, a, b, model_result(op, a, b));
		end

		backpressure_test();
		repeat (2) @(posedge clk);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: gf_alu.f
verilog/gf_pkg.sv
verilog/gf_mult.sv
verilog/gf_cube.sv
verilog/gf_divider.sv
verilog/gf_alu_ctrl.sv
verilog/gf_alu.sv
test/gf_alu_chk.sv
test/gf_alu_tb.sv

// File: Makefile
SOURCES := $(wildcard verilog/*.sv test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vgf_alu_tb: gf_alu.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module gf_alu_tb \
		-f gf_alu.f -o Vgf_alu_tb

sim.log: obj_dir/Vgf_alu_tb
	./obj_dir/Vgf_alu_tb > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
		echo "run failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
